/* ooo_config.svh */
/*
 * sizes shared by the out-of-order back end
 * ROB depth and tag width, data width, register file shape
 */

`ifndef OOO_CONFIG_SVH
`define OOO_CONFIG_SVH

// reorder buffer depth, power of two
`define OOO_ROB_SIZE 8
// log2 of the ROB depth
`define OOO_TAG_WIDTH 3

// data and pc width
`define OOO_XLEN 32

// architectural register file
`define OOO_REG_COUNT 32
`define OOO_REG_WIDTH 5
// r0 is hardwired and never written
`define OOO_ZERO_REG 0

`endif

/* ooo_pkg.sv */
/*
 * shared types for the back end
 * opcode enum and dispatch FSM states
 */

`default_nettype none

package ooo_pkg;

    // instruction classes seen by the back end
    typedef enum logic [1:0] {
        op_alu    = 2'b00,
        op_branch = 2'b01,
        op_halt   = 2'b10
    } opcode_t;

    // dispatch stops accepting after a halt until a squash
    typedef enum logic {
        disp_run    = 1'b0,
        disp_halted = 1'b1
    } dispatch_state_t;

endpackage

`default_nettype wire

/* dispatch_unit.sv */
/*
 * dispatch stage
 * valid/ready intake, ROB credit counter, one-stage issue register
 */

`default_nettype none
`timescale 1ns/1ps
`include "ooo_config.svh"

module dispatch_unit
    import ooo_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      inst_valid,
    input  opcode_t                   inst_opcode,
    input  logic [`OOO_XLEN-1:0]      inst_pc,
    input  logic [`OOO_REG_WIDTH-1:0] inst_dest,
    input  logic                      inst_predict_taken,
    output logic                      inst_ready,
    input  logic                      credit_return,
    input  logic                      squash,
    output logic                      alloc_valid,
    output opcode_t                   alloc_opcode,
    output logic [`OOO_XLEN-1:0]      alloc_pc,
    output logic [`OOO_REG_WIDTH-1:0] alloc_dest,
    output logic                      alloc_predict_taken
);

    localparam int CRED_W = `OOO_TAG_WIDTH + 1;
    localparam logic [CRED_W-1:0] FULL_CREDITS = CRED_W'(`OOO_ROB_SIZE);

    logic [CRED_W-1:0] credits;
    dispatch_state_t   state;
    logic              accept;

    // no intake while out of credits, halted, or flushing
    assign inst_ready = (credits != '0) && (state == disp_run) && !squash;
    assign accept     = inst_valid && inst_ready;

    ////////////////////////////////////////////////////////////
    // credits and FSM
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            credits     <= FULL_CREDITS;
            state       <= disp_run;
            alloc_valid <= 1'b0;
        end else begin
            alloc_valid <= accept;
            if (squash) begin
                // ROB empties on the same edge
                credits <= FULL_CREDITS;
                state   <= disp_run;
            end else begin
                credits <= credits - CRED_W'(accept) + CRED_W'(credit_return);
                if (accept && inst_opcode == op_halt) begin
                    state <= disp_halted;
                end
            end
        end
    end

    // issue payload, only meaningful with alloc_valid
    always_ff @(posedge clock) begin
        if (accept) begin
            alloc_opcode        <= inst_opcode;
            alloc_pc            <= inst_pc;
            alloc_dest          <= inst_dest;
            alloc_predict_taken <= inst_predict_taken;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // a return pulse only follows an earlier acceptance
    credit_bound: assert property (
        @(posedge clock) disable iff (reset) credits <= FULL_CREDITS
    ) else $error("dispatch credit count above ROB size");

endmodule

`default_nettype wire

/* reorder_buffer.sv */
/*
 * reorder buffer
 * circular entry array, CDB completion by tag,
 * in-order retirement and flush on mispredict
 */

`default_nettype none
`timescale 1ns/1ps
`include "ooo_config.svh"

module reorder_buffer
    import ooo_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      alloc_valid,
    input  opcode_t                   alloc_opcode,
    input  logic [`OOO_XLEN-1:0]      alloc_pc,
    input  logic [`OOO_REG_WIDTH-1:0] alloc_dest,
    input  logic                      alloc_predict_taken,
    output logic [`OOO_TAG_WIDTH-1:0] alloc_tag,
    input  logic                      cdb_valid,
    input  logic [`OOO_TAG_WIDTH-1:0] cdb_tag,
    input  logic [`OOO_XLEN-1:0]      cdb_value,
    input  logic                      cdb_taken,
    output logic                      credit_return,
    output logic                      retire_valid,
    output opcode_t                   retire_opcode,
    output logic [`OOO_REG_WIDTH-1:0] retire_dest,
    output logic [`OOO_XLEN-1:0]      retire_value,
    output logic                      retire_squash,
    output logic [`OOO_XLEN-1:0]      retire_redirect_pc
);

    localparam int CNT_W = `OOO_TAG_WIDTH + 1;
    localparam logic [CNT_W-1:0] FULL_COUNT = CNT_W'(`OOO_ROB_SIZE);

    logic [`OOO_TAG_WIDTH-1:0] head;
    logic [`OOO_TAG_WIDTH-1:0] tail;
    logic [CNT_W-1:0]          count;
    logic                      empty;
    logic                      full;

    // entry state
    logic                      entry_valid   [`OOO_ROB_SIZE];
    logic                      entry_ready   [`OOO_ROB_SIZE];
    logic                      entry_mispred [`OOO_ROB_SIZE];
    // entry payload
    opcode_t                   entry_opcode  [`OOO_ROB_SIZE];
    logic [`OOO_XLEN-1:0]      entry_pc      [`OOO_ROB_SIZE];
    logic [`OOO_REG_WIDTH-1:0] entry_dest    [`OOO_ROB_SIZE];
    logic [`OOO_XLEN-1:0]      entry_value   [`OOO_ROB_SIZE];
    logic                      entry_pred    [`OOO_ROB_SIZE];

    assign empty     = (count == '0);
    assign full      = (count == FULL_COUNT);
    assign alloc_tag = tail;

    ////////////////////////////////////////////////////////////
    // head view for retirement
    ////////////////////////////////////////////////////////////

    assign retire_valid  = !empty && entry_ready[head];
    assign retire_squash = retire_valid && entry_mispred[head];
    assign credit_return = retire_valid && !retire_squash;
    assign retire_opcode = entry_opcode[head];
    assign retire_dest   = entry_dest[head];
    assign retire_value  = entry_value[head];

    // predicted taken means the fall-through was skipped,
    // otherwise the stored value holds the branch target
    assign retire_redirect_pc = entry_pred[head] ? entry_pc[head] + `OOO_XLEN'(4)
                                                 : entry_value[head];

    ////////////////////////////////////////////////////////////
    // pointers and entry state
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset || retire_squash) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
            for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
                entry_valid[i] <= 1'b0;
                entry_ready[i] <= 1'b0;
            end
        end else begin
            // completion; a write to the tail being allocated is impossible
            if (cdb_valid && entry_valid[cdb_tag]) begin
                entry_ready[cdb_tag]   <= 1'b1;
                entry_mispred[cdb_tag] <= (entry_opcode[cdb_tag] == op_branch) &&
                                          (cdb_taken != entry_pred[cdb_tag]);
            end
            if (alloc_valid) begin
                entry_valid[tail]   <= 1'b1;
                entry_ready[tail]   <= 1'b0;
                entry_mispred[tail] <= 1'b0;
                tail                <= tail + 1'b1;
            end
            if (retire_valid) begin
                entry_valid[head] <= 1'b0;
                entry_ready[head] <= 1'b0;
                head              <= head + 1'b1;
            end
            count <= count + CNT_W'(alloc_valid) - CNT_W'(retire_valid);
        end
    end

    // payload fields carry no reset
    always_ff @(posedge clock) begin
        if (alloc_valid) begin
            entry_opcode[tail] <= alloc_opcode;
            entry_pc[tail]     <= alloc_pc;
            entry_dest[tail]   <= alloc_dest;
            entry_pred[tail]   <= alloc_predict_taken;
        end
        if (cdb_valid && entry_valid[cdb_tag]) begin
            entry_value[cdb_tag] <= cdb_value;
        end
    end

    ////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////

    // dispatch credits must keep allocation off a full buffer
    no_alloc_when_full: assert property (
        @(posedge clock) disable iff (reset) alloc_valid |-> !full || retire_squash
    ) else $error("ROB allocation while full");

    // the execution side only completes tags it was issued
    cdb_hits_valid: assert property (
        @(posedge clock) disable iff (reset) cdb_valid |-> entry_valid[cdb_tag]
    ) else $error("CDB write to an empty ROB entry");

endmodule

`default_nettype wire

/* retire_unit.sv */
/*
 * retire stage
 * architectural register file, commit and redirect pulses, halt flag
 */

`default_nettype none
`timescale 1ns/1ps
`include "ooo_config.svh"

module retire_unit
    import ooo_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    input  logic                      retire_valid,
    input  opcode_t                   retire_opcode,
    input  logic [`OOO_REG_WIDTH-1:0] retire_dest,
    input  logic [`OOO_XLEN-1:0]      retire_value,
    input  logic                      retire_squash,
    input  logic [`OOO_XLEN-1:0]      retire_redirect_pc,
    output logic                      commit_valid,
    output logic [`OOO_REG_WIDTH-1:0] commit_dest,
    output logic [`OOO_XLEN-1:0]      commit_value,
    output logic                      redirect_valid,
    output logic [`OOO_XLEN-1:0]      redirect_pc,
    output logic                      halted,
    input  logic [`OOO_REG_WIDTH-1:0] arch_read_idx,
    output logic [`OOO_XLEN-1:0]      arch_read_value
);

    logic [`OOO_XLEN-1:0] arch_regs [`OOO_REG_COUNT];
    logic                 reg_write;

    // only alu results reach the register file, r0 stays zero
    assign reg_write = retire_valid && (retire_opcode == op_alu) &&
                       (retire_dest != `OOO_REG_WIDTH'(`OOO_ZERO_REG));

    assign arch_read_value = arch_regs[arch_read_idx];

    ////////////////////////////////////////////////////////////
    // architectural state
    ////////////////////////////////////////////////////////////

    // registers read as zero out of reset
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int i = 0; i < `OOO_REG_COUNT; i++) begin
                arch_regs[i] <= '0;
            end
        end else if (reg_write) begin
            arch_regs[retire_dest] <= retire_value;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            commit_valid   <= 1'b0;
            redirect_valid <= 1'b0;
            halted         <= 1'b0;
        end else begin
            commit_valid   <= retire_valid;
            redirect_valid <= retire_squash;
            // sticky until reset
            if (retire_valid && retire_opcode == op_halt) begin
                halted <= 1'b1;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (retire_valid) begin
            commit_dest  <= retire_dest;
            commit_value <= retire_value;
        end
        if (retire_squash) begin
            redirect_pc <= retire_redirect_pc;
        end
    end

endmodule

`default_nettype wire

/* ooo_core_top.sv */
/*
 * back-end top level
 * dispatch, reorder buffer and retire stage
 */

`default_nettype none
`timescale 1ns/1ps
`include "ooo_config.svh"

module ooo_core_top
    import ooo_pkg::*;
(
    input  logic                      clock,
    input  logic                      reset,
    // decoded instruction intake
    input  logic                      inst_valid,
    input  opcode_t                   inst_opcode,
    input  logic [`OOO_XLEN-1:0]      inst_pc,
    input  logic [`OOO_REG_WIDTH-1:0] inst_dest,
    input  logic                      inst_predict_taken,
    output logic                      inst_ready,
    // tag handed to the execution side
    output logic                      issue_valid,
    output logic [`OOO_TAG_WIDTH-1:0] issue_tag,
    // common data bus
    input  logic                      cdb_valid,
    input  logic [`OOO_TAG_WIDTH-1:0] cdb_tag,
    input  logic [`OOO_XLEN-1:0]      cdb_value,
    input  logic                      cdb_taken,
    // commit side
    output logic                      commit_valid,
    output logic [`OOO_REG_WIDTH-1:0] commit_dest,
    output logic [`OOO_XLEN-1:0]      commit_value,
    output logic                      redirect_valid,
    output logic [`OOO_XLEN-1:0]      redirect_pc,
    output logic                      halted,
    input  logic [`OOO_REG_WIDTH-1:0] arch_read_idx,
    output logic [`OOO_XLEN-1:0]      arch_read_value
);

    logic                      alloc_valid;
    opcode_t                   alloc_opcode;
    logic [`OOO_XLEN-1:0]      alloc_pc;
    logic [`OOO_REG_WIDTH-1:0] alloc_dest;
    logic                      alloc_predict_taken;
    logic [`OOO_TAG_WIDTH-1:0] alloc_tag;
    logic                      credit_return;
    logic                      retire_valid;
    opcode_t                   retire_opcode;
    logic [`OOO_REG_WIDTH-1:0] retire_dest;
    logic [`OOO_XLEN-1:0]      retire_value;
    logic                      retire_squash;
    logic [`OOO_XLEN-1:0]      retire_redirect_pc;

    // the entry written this cycle is the one the execution side must complete
    assign issue_valid = alloc_valid;
    assign issue_tag   = alloc_tag;

    dispatch_unit u_dispatch (
        .clock               (clock),
        .reset               (reset),
        .inst_valid          (inst_valid),
        .inst_opcode         (inst_opcode),
        .inst_pc             (inst_pc),
        .inst_dest           (inst_dest),
        .inst_predict_taken  (inst_predict_taken),
        .inst_ready          (inst_ready),
        .credit_return       (credit_return),
        .squash              (retire_squash),
        .alloc_valid         (alloc_valid),
        .alloc_opcode        (alloc_opcode),
        .alloc_pc            (alloc_pc),
        .alloc_dest          (alloc_dest),
        .alloc_predict_taken (alloc_predict_taken)
    );

    reorder_buffer u_rob (
        .clock               (clock),
        .reset               (reset),
        .alloc_valid         (alloc_valid),
        .alloc_opcode        (alloc_opcode),
        .alloc_pc            (alloc_pc),
        .alloc_dest          (alloc_dest),
        .alloc_predict_taken (alloc_predict_taken),
        .alloc_tag           (alloc_tag),
        .cdb_valid           (cdb_valid),
        .cdb_tag             (cdb_tag),
        .cdb_value           (cdb_value),
        .cdb_taken           (cdb_taken),
        .credit_return       (credit_return),
        .retire_valid        (retire_valid),
        .retire_opcode       (retire_opcode),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .retire_squash       (retire_squash),
        .retire_redirect_pc  (retire_redirect_pc)
    );

    retire_unit u_retire (
        .clock               (clock),
        .reset               (reset),
        .retire_valid        (retire_valid),
        .retire_opcode       (retire_opcode),
        .retire_dest         (retire_dest),
        .retire_value        (retire_value),
        .retire_squash       (retire_squash),
        .retire_redirect_pc  (retire_redirect_pc),
        .commit_valid        (commit_valid),
        .commit_dest         (commit_dest),
        .commit_value        (commit_value),
        .redirect_valid      (redirect_valid),
        .redirect_pc         (redirect_pc),
        .halted              (halted),
        .arch_read_idx       (arch_read_idx),
        .arch_read_value     (arch_read_value)
    );

endmodule

`default_nettype wire

/* tb_ooo_core.sv */
/*
 * directed testbench for the out-of-order back end
 * program-order model, LCG stimulus, compare tasks and the tests
 */

`default_nettype none
`timescale 1ns/1ps
`include "ooo_config.svh"

module tb_ooo_core
    import ooo_pkg::*;
();

    localparam int WAIT_LIMIT = 60;

    logic                      clock;
    logic                      reset;
    logic                      inst_valid;
    opcode_t                   inst_opcode;
    logic [`OOO_XLEN-1:0]      inst_pc;
    logic [`OOO_REG_WIDTH-1:0] inst_dest;
    logic                      inst_predict_taken;
    logic                      inst_ready;
    logic                      issue_valid;
    logic [`OOO_TAG_WIDTH-1:0] issue_tag;
    logic                      cdb_valid;
    logic [`OOO_TAG_WIDTH-1:0] cdb_tag;
    logic [`OOO_XLEN-1:0]      cdb_value;
    logic                      cdb_taken;
    logic                      commit_valid;
    logic [`OOO_REG_WIDTH-1:0] commit_dest;
    logic [`OOO_XLEN-1:0]      commit_value;
    logic                      redirect_valid;
    logic [`OOO_XLEN-1:0]      redirect_pc;
    logic                      halted;
    logic [`OOO_REG_WIDTH-1:0] arch_read_idx;
    logic [`OOO_XLEN-1:0]      arch_read_value;

    // model of accepted instructions indexed by program order
    opcode_t                   m_op    [256];
    logic [`OOO_XLEN-1:0]      m_pc    [256];
    logic [`OOO_REG_WIDTH-1:0] m_dest  [256];
    logic [`OOO_XLEN-1:0]      m_value [256];
    logic                      m_pred  [256];
    logic                      m_taken [256];
    logic [`OOO_TAG_WIDTH-1:0] m_tag   [256];
    logic [`OOO_XLEN-1:0]      ref_regs [`OOO_REG_COUNT];
    int                        pend_q[$];   // waiting for commit
    int                        open_q[$];   // waiting for the CDB
    int                        seq_count;
    int                        commits_seen;
    int                        mon_seq;
    logic                      mon_mispred;
    logic [`OOO_XLEN-1:0]      pc_next;
    // tags follow the ROB tail in program order
    logic [`OOO_TAG_WIDTH-1:0] exp_tag;
    logic [31:0]               lcg_state;

    ooo_core_top DUT (.*);

    always #20 clock = ~clock;

    ////////////////////////////////////////////////////////////
    // failure reporting and compare tasks
    ////////////////////////////////////////////////////////////

    task automatic stop_run();
        $display("Test failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic abort_with(input string what);
        $display("error at %0t: %s", $time, what);
        stop_run();
    endtask

    task automatic compare_commit(input logic [`OOO_REG_WIDTH-1:0] got_dest,
                                  input logic [`OOO_REG_WIDTH-1:0] exp_dest,
                                  input logic [`OOO_XLEN-1:0] got_value,
                                  input logic [`OOO_XLEN-1:0] exp_value);
        if (got_dest !== exp_dest || got_value !== exp_value) begin
            $display("mismatch at %0t: commit r%0d=%h, expected r%0d=%h",
                     $time, got_dest, got_value, exp_dest, exp_value);
            stop_run();
        end
    endtask

    task automatic compare_redirect(input logic [`OOO_XLEN-1:0] got,
                                    input logic [`OOO_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: redirect pc %h, expected %h", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_reg(input logic [`OOO_REG_WIDTH-1:0] idx,
                               input logic [`OOO_XLEN-1:0] got,
                               input logic [`OOO_XLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: r%0d reads %h, expected %h", $time, idx, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_tag(input logic [`OOO_TAG_WIDTH-1:0] got,
                               input logic [`OOO_TAG_WIDTH-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: issue tag %0d, expected %0d", $time, got, exp);
            stop_run();
        end
    endtask

    task automatic compare_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("mismatch at %0t: %s is %b, expected %b", $time, what, got, exp);
            stop_run();
        end
    endtask

    // next LCG value from the upper half of the state
    function automatic logic [15:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state[31:16];
    endfunction

    function automatic logic [31:0] rand_word();
        return {lcg_next(), lcg_next()};
    endfunction

    ////////////////////////////////////////////////////////////
    // commit monitor checking every retirement against the model
    ////////////////////////////////////////////////////////////

    always @(negedge clock) begin
        if (!reset && commit_valid) begin
            if (pend_q.size() == 0) begin
                abort_with("a commit appeared while no instruction was pending");
            end else begin
                mon_seq = pend_q.pop_front();
                mon_mispred = (m_op[mon_seq] == op_branch) &&
                              (m_taken[mon_seq] != m_pred[mon_seq]);
                compare_commit(commit_dest, m_dest[mon_seq], commit_value, m_value[mon_seq]);
                compare_flag(redirect_valid, mon_mispred, "redirect_valid at commit");
                if (mon_mispred) begin
                    compare_redirect(redirect_pc, m_pred[mon_seq] ? m_pc[mon_seq] + 32'd4
                                                                  : m_value[mon_seq]);
                    // everything younger is flushed
                    pend_q.delete();
                    open_q.delete();
                    // the emptied ROB allocates from slot 0 again
                    exp_tag = '0;
                end else if (m_op[mon_seq] == op_alu && m_dest[mon_seq] != `OOO_ZERO_REG) begin
                    ref_regs[m_dest[mon_seq]] = m_value[mon_seq];
                end
                commits_seen++;
            end
        end else if (!reset && redirect_valid) begin
            abort_with("redirect_valid pulsed without a commit");
        end
    end

    ////////////////////////////////////////////////////////////
    // drivers
    ////////////////////////////////////////////////////////////

    task automatic dispatch_inst(input opcode_t op, input logic [`OOO_REG_WIDTH-1:0] dest,
                                 input logic pred, output int seq);
        int waited;
        @(negedge clock);
        inst_valid         = 1'b1;
        inst_opcode        = op;
        inst_pc            = pc_next;
        inst_dest          = dest;
        inst_predict_taken = pred;
        #1;
        waited = 0;
        while (!inst_ready) begin
            @(negedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_with("inst_ready stayed low during dispatch");
        end
        @(posedge clock);
        @(negedge clock);
        inst_valid = 1'b0;
        #1;
        compare_flag(issue_valid, 1'b1, "issue_valid after acceptance");
        compare_tag(issue_tag, exp_tag);
        seq = seq_count;
        m_op[seq]   = op;
        m_pc[seq]   = pc_next;
        m_dest[seq] = dest;
        m_pred[seq] = pred;
        m_tag[seq]  = issue_tag;
        pend_q.push_back(seq);
        open_q.push_back(seq);
        seq_count++;
        exp_tag = exp_tag + 1'b1;
        pc_next += 32'd4;
    endtask

    // one CDB write for the entry of a model instruction
    task automatic complete_entry(input int seq, input logic [`OOO_XLEN-1:0] value,
                                  input logic taken);
        for (int i = 0; i < open_q.size(); i++) begin
            if (open_q[i] == seq) begin
                open_q.delete(i);
                break;
            end
        end
        m_value[seq] = value;
        m_taken[seq] = taken;
        @(negedge clock);
        cdb_valid = 1'b1;
        cdb_tag   = m_tag[seq];
        cdb_value = value;
        cdb_taken = taken;
        @(negedge clock);
        cdb_valid = 1'b0;
    endtask

    task automatic complete_open_shuffled();
        int pick;
        while (open_q.size() > 0) begin
            pick = int'(lcg_next()) % open_q.size();
            complete_entry(open_q[pick], rand_word(), 1'b0);
        end
    endtask

    task automatic wait_commits(input int target);
        int waited;
        waited = 0;
        while (commits_seen < target) begin
            @(negedge clock);
            #1;
            waited++;
            if (waited > WAIT_LIMIT) abort_with("expected commits did not arrive");
        end
    endtask

    task automatic idle_cycles(input int n);
        repeat (n) @(negedge clock);
        #1;
    endtask

    task automatic check_all_regs();
        for (int i = 0; i < `OOO_REG_COUNT; i++) begin
            @(negedge clock);
            arch_read_idx = `OOO_REG_WIDTH'(i);
            #1;
            compare_reg(arch_read_idx, arch_read_value, ref_regs[i]);
        end
    endtask

    task automatic fill_rob();
        int seq;
        for (int i = 0; i < `OOO_ROB_SIZE; i++) begin
            dispatch_inst(op_alu, `OOO_REG_WIDTH'(i + 1), 1'b0, seq);
        end
        compare_flag(inst_ready, 1'b0, "inst_ready with the ROB full");
    endtask

    ////////////////////////////////////////////////////////////
    // tests
    ////////////////////////////////////////////////////////////

    task automatic reset_state_check();
        #1;
        compare_flag(inst_ready, 1'b1, "inst_ready after reset");
        compare_flag(issue_valid, 1'b0, "issue_valid after reset");
        compare_flag(commit_valid, 1'b0, "commit_valid after reset");
        compare_flag(redirect_valid, 1'b0, "redirect_valid after reset");
        compare_flag(halted, 1'b0, "halted after reset");
        check_all_regs();
    endtask

    task automatic in_order_commit();
        int seq;
        int target;
        target = commits_seen + 6;
        // small dest range so some registers are written twice and one op targets r0
        for (int i = 0; i < 6; i++) begin
            dispatch_inst(op_alu, (i == 1) ? '0 : `OOO_REG_WIDTH'(lcg_next() % 8), 1'b0, seq);
        end
        complete_open_shuffled();
        wait_commits(target);
        check_all_regs();
    endtask

    task automatic credit_backpressure();
        int seq;
        int target;
        target = commits_seen + `OOO_ROB_SIZE + 1;
        fill_rob();
        idle_cycles(2);
        compare_flag(inst_ready, 1'b0, "inst_ready while out of credits");
        complete_entry(open_q[0], rand_word(), 1'b0);
        dispatch_inst(op_alu, 5'd9, 1'b0, seq);
        compare_flag(inst_ready, 1'b0, "inst_ready after the returned credit is used");
        complete_open_shuffled();
        wait_commits(target);
    endtask

    task automatic mispredict_squash();
        int sb;
        int sa;
        int target;
        // branch predicted not taken and resolved taken while younger ops finish first
        dispatch_inst(op_branch, '0, 1'b0, sb);
        dispatch_inst(op_alu, 5'd3, 1'b0, sa);
        complete_entry(sa, rand_word(), 1'b0);
        dispatch_inst(op_alu, 5'd4, 1'b0, sa);
        complete_entry(sa, rand_word(), 1'b0);
        target = commits_seen + 1;
        complete_entry(sb, 32'h0000_2000, 1'b1);
        wait_commits(target);
        idle_cycles(4);
        compare_flag(inst_ready, 1'b1, "inst_ready after the squash");
        // branch predicted taken and resolved not taken
        dispatch_inst(op_branch, '0, 1'b1, sb);
        dispatch_inst(op_alu, 5'd6, 1'b0, sa);
        complete_entry(sa, rand_word(), 1'b0);
        target = commits_seen + 1;
        complete_entry(sb, rand_word(), 1'b0);
        wait_commits(target);
        idle_cycles(4);
        check_all_regs();
        // full credits are back
        target = commits_seen + `OOO_ROB_SIZE;
        fill_rob();
        complete_open_shuffled();
        wait_commits(target);
    endtask

    task automatic correct_prediction();
        int s1;
        int s2;
        int target;
        target = commits_seen + 2;
        dispatch_inst(op_branch, 5'd7, 1'b1, s1);
        dispatch_inst(op_branch, 5'd8, 1'b0, s2);
        complete_entry(s1, rand_word(), 1'b1);
        complete_entry(s2, rand_word(), 1'b0);
        wait_commits(target);
        check_all_regs();
    endtask

    task automatic halt_behavior();
        int sh;
        int target;
        target = commits_seen + 1;
        dispatch_inst(op_halt, '0, 1'b0, sh);
        compare_flag(inst_ready, 1'b0, "inst_ready after a halt");
        compare_flag(halted, 1'b0, "halted before the halt retires");
        complete_entry(sh, '0, 1'b0);
        wait_commits(target);
        compare_flag(halted, 1'b1, "halted after the halt retires");
        idle_cycles(3);
        compare_flag(halted, 1'b1, "halted some cycles later");
        compare_flag(inst_ready, 1'b0, "inst_ready while halted");
    endtask

    initial begin
        clock              = 1'b0;
        reset              = 1'b1;
        inst_valid         = 1'b0;
        inst_opcode        = op_alu;
        inst_pc            = '0;
        inst_dest          = '0;
        inst_predict_taken = 1'b0;
        cdb_valid          = 1'b0;
        cdb_tag            = '0;
        cdb_value          = '0;
        cdb_taken          = 1'b0;
        arch_read_idx      = '0;
        lcg_state          = 32'd86;
        seq_count          = 0;
        commits_seen       = 0;
        exp_tag            = '0;
        pc_next            = 32'h0000_1000;
        for (int i = 0; i < `OOO_REG_COUNT; i++) begin
            ref_regs[i] = '0;
        end
        repeat (2) @(posedge clock);
        @(negedge clock);
        reset = 1'b0;

        reset_state_check();
        in_order_commit();
        credit_backpressure();
        mispredict_squash();
        correct_prediction();
        halt_behavior();

        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+.
ooo_pkg.sv
dispatch_unit.sv
reorder_buffer.sv
retire_unit.sv
ooo_core_top.sv
tb_ooo_core.sv

/* run_sim.sh */
#!/bin/sh
# compile the testbench with Verilator, run it, and judge the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f sources.f \
    --top-module tb_ooo_core --Mdir obj_dir -o tb_ooo_core > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "compile failed, see build.log"
    exit 1
fi

./obj_dir/tb_ooo_core > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "Test completed successfully" sim.log; then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi
